// ==== cps_video_params.svh ====
/*
 * Raster geometry, widths and register map of the video block.
 * Sizes are fixed by the hardware format and are not meant to be changed.
 */
`ifndef CPS_VIDEO_PARAMS_SVH
`define CPS_VIDEO_PARAMS_SVH

// Horizontal geometry in pixels
`define CPS_H_TOTAL     448
`define CPS_H_ACTIVE    384
`define CPS_HS_START    400
`define CPS_HS_END      431

// Vertical geometry in lines
`define CPS_V_TOTAL     262
`define CPS_V_ACTIVE    224
`define CPS_VS_START    236
`define CPS_VS_END      239

// Widths
`define CPS_HW          9
`define CPS_VW          9
`define CPS_AW          12
`define CPS_DW          16
`define CPS_PAL_AW      11
`define CPS_RGBW        8

// Pixel enables from layer input to RGB
`define CPS_PIPE_DLY    3

// Register window offsets and transparent colour
`define CPS_REG_LAYER   0
`define CPS_REG_RASTER  1
`define CPS_TRANSP      15

`endif

// ==== cps_pkg.sv ====
/*
 * Shared types of the video block.
 * Struct members are listed MSB first.
 */
`include "cps_video_params.svh"

package cps_pkg;

    typedef logic [`CPS_HW-1:0]     hcount_t;
    typedef logic [`CPS_VW-1:0]     vcount_t;
    typedef logic [`CPS_AW-1:0]     cpu_addr_t;
    typedef logic [`CPS_DW-1:0]     cpu_data_t;
    typedef logic [15:0]            pal_word_t;
    typedef logic [`CPS_PAL_AW-1:0] pal_addr_t;
    typedef logic [15:0]            layer_ctrl_t;
    typedef logic [`CPS_RGBW-1:0]   rgb_t;

    // One rendered layer pixel
    typedef struct packed {
        logic [4:0] pal;
        logic [3:0] color;
    } layer_pxl_t;

    // Layer ids 0 to 3 in this order
    typedef struct packed {
        layer_pxl_t obj;
        layer_pxl_t scr1;
        layer_pxl_t scr2;
        layer_pxl_t scr3;
    } layers_t;

    typedef struct packed {
        hcount_t hdump;
        vcount_t vdump;
        logic    hs;
        logic    vs;
        logic    hb;
        logic    vb;
        logic    line_start;
        logic    frame_start;
    } video_timing_t;

    typedef struct packed {
        logic      we;
        pal_addr_t addr;
        pal_word_t data;
    } pal_wr_t;

endpackage

// ==== cps_timing.sv ====
/*
 * Raster counters with registered sync, blanking and start pulses.
 * Counters move only on pxl_cen; line_start and frame_start last one clk.
 */
`timescale 1ns/100ps
`include "cps_video_params.svh"

module cps_timing (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    output cps_pkg::video_timing_t timing
);

    import cps_pkg::*;

    hcount_t h_nxt;
    vcount_t v_nxt;

    // Next raster position
    always_comb begin
        h_nxt = timing.hdump + 1'b1;
        v_nxt = timing.vdump;
        if (timing.hdump == hcount_t'(`CPS_H_TOTAL - 1)) begin
            h_nxt = '0;
            if (timing.vdump == vcount_t'(`CPS_V_TOTAL - 1)) begin
                v_nxt = '0;
            end else begin
                v_nxt = timing.vdump + 1'b1;
            end
        end
    end

    // Flags are computed from the next position so they stay aligned with the counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            timing <= '0;
        end else begin
            timing.line_start  <= 1'b0;
            timing.frame_start <= 1'b0;
            if (pxl_cen) begin
                timing.hdump <= h_nxt;
                timing.vdump <= v_nxt;
                timing.hb    <= h_nxt >= hcount_t'(`CPS_H_ACTIVE);
                timing.vb    <= v_nxt >= vcount_t'(`CPS_V_ACTIVE);
                timing.hs    <= h_nxt >= hcount_t'(`CPS_HS_START) &&
                                h_nxt <= hcount_t'(`CPS_HS_END);
                timing.vs    <= v_nxt >= vcount_t'(`CPS_VS_START) &&
                                v_nxt <= vcount_t'(`CPS_VS_END);
                timing.line_start  <= h_nxt == '0;
                timing.frame_start <= h_nxt == '0 && v_nxt == '0;
            end
        end
    end

endmodule

// ==== cps_mmr.sv ====
/*
 * The top address bit of the CPU port selects the register window, else the palette.
 * The palette is write-only and reads back as 0.
 * Palette writes leave as one-clk strobes one clk after the bus write.
 */
`timescale 1ns/100ps
`include "cps_video_params.svh"

module cps_mmr (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cs,
    input  logic                   we,
    input  cps_pkg::cpu_addr_t     addr,
    input  cps_pkg::cpu_data_t     wdata,
    output cps_pkg::cpu_data_t     rdata,
    input  cps_pkg::video_timing_t timing,
    output cps_pkg::layer_ctrl_t   layer_ctrl,
    output cps_pkg::pal_wr_t       pal_wr,
    output logic                   raster
);

    import cps_pkg::*;

    logic             reg_sel;
    pal_addr_t        win_addr;
    vcount_t          raster_line;
    cpu_data_t        rd_mux;
    logic             pal_we;
    pal_addr_t        pal_waddr;
    pal_word_t        pal_wdata;

    assign reg_sel  = addr[`CPS_AW-1];
    assign win_addr = addr[`CPS_PAL_AW-1:0];

    // Register writes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            layer_ctrl  <= '0;
            raster_line <= '1;
        end else if (cs && we && reg_sel) begin
            if (win_addr == pal_addr_t'(`CPS_REG_LAYER)) begin
                layer_ctrl <= wdata;
            end
            if (win_addr == pal_addr_t'(`CPS_REG_RASTER)) begin
                raster_line <= wdata[`CPS_VW-1:0];
            end
        end
    end

    always_comb begin
        rd_mux = '0;
        if (reg_sel) begin
            if (win_addr == pal_addr_t'(`CPS_REG_LAYER)) begin
                rd_mux = layer_ctrl;
            end else if (win_addr == pal_addr_t'(`CPS_REG_RASTER)) begin
                rd_mux = cpu_data_t'(raster_line);
            end
        end
    end

    // Read data holds until the next read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else if (cs && !we) begin
            rdata <= rd_mux;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal_we <= 1'b0;
        end else begin
            pal_we <= cs && we && !reg_sel;
        end
    end

    always_ff @(posedge clk) begin
        pal_waddr <= win_addr;
        pal_wdata <= wdata;
    end

    assign pal_wr = '{we: pal_we, addr: pal_waddr, data: pal_wdata};

    // The interrupt is as wide as line_start, a single clk
    assign raster = timing.line_start && timing.vdump == raster_line;

endmodule

// ==== cps_colmix.sv ====
/*
 * Layer mixer, one pixel enable of latency.
 * The order fields are walked front to back; colour 15 is transparent.
 * All layers transparent or disabled gives the background index 0x7FF.
 */
`timescale 1ns/100ps
`include "cps_video_params.svh"

module cps_colmix (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  cps_pkg::layers_t     layers,
    input  cps_pkg::layer_ctrl_t layer_ctrl,
    output cps_pkg::pal_addr_t   mix_addr
);

    import cps_pkg::*;

    layer_pxl_t by_id[4];
    logic [3:0] layer_en;
    pal_addr_t  sel_addr;

    // Index pixels by layer id
    assign by_id[0] = layers.obj;
    assign by_id[1] = layers.scr1;
    assign by_id[2] = layers.scr2;
    assign by_id[3] = layers.scr3;

    assign layer_en = layer_ctrl[11:8];

    always_comb begin
        logic       found;
        logic [1:0] id;
        found    = 1'b0;
        sel_addr = '1;
        for (int i = 0; i < 4; i++) begin
            id = layer_ctrl[2*i +: 2];
            if (!found && layer_en[id] &&
                by_id[id].color != 4'(`CPS_TRANSP)) begin
                found    = 1'b1;
                sel_addr = {id, by_id[id].pal, by_id[id].color};
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mix_addr <= '1;
        end else if (pxl_cen) begin
            mix_addr <= sel_addr;
        end
    end

endmodule

// ==== cps_palette.sv ====
/*
 * Palette RAM and colour output, two pixel enables from mix_addr to RGB.
 * Word format is brightness[15:12], red[11:8], green[7:4], blue[3:0].
 * A write in flight is forwarded to a read of the same index.
 */
`timescale 1ns/100ps
`include "cps_video_params.svh"

module cps_palette (
    input  logic               clk,
    input  logic               rst,
    input  logic               pxl_cen,
    input  cps_pkg::pal_wr_t   pal_wr,
    input  cps_pkg::pal_addr_t mix_addr,
    input  logic               hb,
    input  logic               vb,
    output cps_pkg::rgb_t      red,
    output cps_pkg::rgb_t      green,
    output cps_pkg::rgb_t      blue,
    output logic               lhbl_dly,
    output logic               lvbl_dly
);

    import cps_pkg::*;

    pal_word_t                 pal_ram[2**`CPS_PAL_AW];
    pal_word_t                 pal_q;
    logic [`CPS_PIPE_DLY-2:0]  hb_sr;
    logic [`CPS_PIPE_DLY-2:0]  vb_sr;
    logic                      blank;

    // Nibble times (16 + brightness), halved
    function automatic rgb_t scale(input logic [3:0] col, input logic [3:0] bright);
        logic [8:0] prod;
        prod = col * (5'd16 + {1'b0, bright});
        return prod[8:1];
    endfunction

    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            pal_ram[pal_wr.addr] <= pal_wr.data;
        end
    end

    // Video read port
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (pal_wr.we && pal_wr.addr == mix_addr) begin
                pal_q <= pal_wr.data;
            end else begin
                pal_q <= pal_ram[mix_addr];
            end
        end
    end

    // Blanking as seen by the pixel entering the output stage
    assign blank = hb_sr[`CPS_PIPE_DLY-2] || vb_sr[`CPS_PIPE_DLY-2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hb_sr    <= '0;
            vb_sr    <= '0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else if (pxl_cen) begin
            hb_sr    <= {hb_sr[`CPS_PIPE_DLY-3:0], hb};
            vb_sr    <= {vb_sr[`CPS_PIPE_DLY-3:0], vb};
            lhbl_dly <= !hb_sr[`CPS_PIPE_DLY-2];
            lvbl_dly <= !vb_sr[`CPS_PIPE_DLY-2];
            if (blank) begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end else begin
                red   <= scale(pal_q[11:8], pal_q[15:12]);
                green <= scale(pal_q[7:4],  pal_q[15:12]);
                blue  <= scale(pal_q[3:0],  pal_q[15:12]);
            end
        end
    end

endmodule

// ==== cps_video.sv ====
/*
 * Video block top wiring the timing, CPU port, layer mixer and palette.
 * Layer pixels arrive already rendered and RGB follows them by 3 pixel enables.
 */
`timescale 1ns/100ps

module cps_video (
    input  logic               clk,
    input  logic               rst,
    input  logic               pxl_cen,
    // CPU bus
    input  logic               cs,
    input  logic               we,
    input  cps_pkg::cpu_addr_t addr,
    input  cps_pkg::cpu_data_t wdata,
    output cps_pkg::cpu_data_t rdata,
    // Rendered layers
    input  cps_pkg::layers_t   layers,
    // Raster
    output cps_pkg::hcount_t   hdump,
    output cps_pkg::vcount_t   vdump,
    output logic               hs,
    output logic               vs,
    output logic               hb,
    output logic               vb,
    output logic               raster,
    // Video out
    output cps_pkg::rgb_t      red,
    output cps_pkg::rgb_t      green,
    output cps_pkg::rgb_t      blue,
    output logic               lhbl_dly,
    output logic               lvbl_dly
);

    import cps_pkg::*;

    video_timing_t timing;
    layer_ctrl_t   layer_ctrl;
    pal_wr_t       pal_wr;
    pal_addr_t     mix_addr;

    assign hdump = timing.hdump;
    assign vdump = timing.vdump;
    assign hs    = timing.hs;
    assign vs    = timing.vs;
    assign hb    = timing.hb;
    assign vb    = timing.vb;

    cps_timing u_timing (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .pxl_cen    ( pxl_cen    ),
        .timing     ( timing     )
    );

    cps_mmr u_mmr (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cs         ( cs         ),
        .we         ( we         ),
        .addr       ( addr       ),
        .wdata      ( wdata      ),
        .rdata      ( rdata      ),
        .timing     ( timing     ),
        .layer_ctrl ( layer_ctrl ),
        .pal_wr     ( pal_wr     ),
        .raster     ( raster     )
    );

    cps_colmix u_colmix (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .pxl_cen    ( pxl_cen    ),
        .layers     ( layers     ),
        .layer_ctrl ( layer_ctrl ),
        .mix_addr   ( mix_addr   )
    );

    cps_palette u_palette (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .pxl_cen    ( pxl_cen    ),
        .pal_wr     ( pal_wr     ),
        .mix_addr   ( mix_addr   ),
        .hb         ( timing.hb  ),
        .vb         ( timing.vb  ),
        .red        ( red        ),
        .green      ( green      ),
        .blue       ( blue       ),
        .lhbl_dly   ( lhbl_dly   ),
        .lvbl_dly   ( lvbl_dly   )
    );

endmodule

// ==== cps_video_checker.sv ====
/*
 * Timing and blanking properties, bound to the video top level.
 * All properties are off while rst is high.
 */
`timescale 1ns/100ps
`include "cps_video_params.svh"

module cps_video_checker (
    input logic             clk,
    input logic             rst,
    input cps_pkg::hcount_t hdump,
    input logic             hs,
    input logic             hb,
    input logic             raster,
    input cps_pkg::rgb_t    red,
    input cps_pkg::rgb_t    green,
    input cps_pkg::rgb_t    blue,
    input logic             lhbl_dly,
    input logic             lvbl_dly
);

    import cps_pkg::*;

    a_hb_range: assert property (@(posedge clk) disable iff (rst)
        hb |-> hdump >= hcount_t'(`CPS_H_ACTIVE))
        else $error("hb high inside the active line at hdump %0d", hdump);

    // Sync sits inside horizontal blanking
    a_hs_in_hb: assert property (@(posedge clk) disable iff (rst) hs |-> hb)
        else $error("hs high outside horizontal blanking");

    a_raster_pulse: assert property (@(posedge clk) disable iff (rst) raster |=> !raster)
        else $error("raster high for more than one clock");

    a_rgb_blank: assert property (@(posedge clk) disable iff (rst)
        (!lhbl_dly || !lvbl_dly) |-> (red == '0 && green == '0 && blue == '0))
        else $error("rgb not zero during blanking");

endmodule

bind cps_video cps_video_checker u_checker (
    .clk      ( clk      ),
    .rst      ( rst      ),
    .hdump    ( hdump    ),
    .hs       ( hs       ),
    .hb       ( hb       ),
    .raster   ( raster   ),
    .red      ( red      ),
    .green    ( green    ),
    .blue     ( blue     ),
    .lhbl_dly ( lhbl_dly ),
    .lvbl_dly ( lvbl_dly )
);

// ==== tb_cps_video.sv ====
/*
 * Testbench for the video block. pxl_cen is held high, so one clk is one pixel.
 * Palette words are random from a fixed-seed LFSR and mirrored here for the checks.
 */
`timescale 1ns/100ps
`include "cps_video_params.svh"

module tb_cps_video;

    import cps_pkg::*;

    localparam int FRAME_CLKS = `CPS_H_TOTAL * `CPS_V_TOTAL;

    // One row of the mixing table
    typedef struct packed {
        layer_ctrl_t ctrl;
        layers_t     layers;
        pal_addr_t   exp_idx;
    } mix_row_t;

    logic      clk;
    logic      rst;
    logic      pxl_cen;
    logic      cs;
    logic      we;
    cpu_addr_t addr;
    cpu_data_t wdata;
    cpu_data_t rdata;
    layers_t   layers;
    hcount_t   hdump;
    vcount_t   vdump;
    logic      hs, vs, hb, vb, raster;
    rgb_t      red, green, blue;
    logic      lhbl_dly, lvbl_dly;

    pal_word_t mirror[2**`CPS_PAL_AW];
    mix_row_t  rows[$];
    logic [15:0] lfsr_state;
    int        errors;
    int        tests;
    int        tests_ok;

    cps_video u_dut (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .cs       ( cs       ),
        .we       ( we       ),
        .addr     ( addr     ),
        .wdata    ( wdata    ),
        .rdata    ( rdata    ),
        .layers   ( layers   ),
        .hdump    ( hdump    ),
        .vdump    ( vdump    ),
        .hs       ( hs       ),
        .vs       ( vs       ),
        .hb       ( hb       ),
        .vb       ( vb       ),
        .raster   ( raster   ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .lhbl_dly ( lhbl_dly ),
        .lvbl_dly ( lvbl_dly )
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Inputs change and outputs are sampled 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            tests_ok++;
            $display("[ok]  %s", name);
        end else begin
            $display("[bad] %s, %0d errors", name, errors - err0);
        end
    endtask

    task automatic cpu_write(input cpu_addr_t a, input cpu_data_t d);
        cs    = 1'b1;
        we    = 1'b1;
        addr  = a;
        wdata = d;
        next_cycle();
        cs    = 1'b0;
        we    = 1'b0;
    endtask

    task automatic cpu_read(input cpu_addr_t a, output cpu_data_t d);
        cs   = 1'b1;
        we   = 1'b0;
        addr = a;
        next_cycle();
        cs   = 1'b0;
        d    = rdata;
    endtask

    // Galois LFSR with taps 0xB400
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_word(output pal_word_t w);
        w = '0;
        for (int b = 0; b < 16; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w          = {w[14:0], lfsr_state[0]};
        end
    endtask

    // Colour nibble times (16 + brightness), halved
    function automatic rgb_t exp_channel(input logic [3:0] nib, input logic [3:0] bright);
        int v;
        v = (int'(nib) * (16 + int'(bright))) / 2;
        return rgb_t'(v);
    endfunction

    function automatic layer_pxl_t pxl(input logic [4:0] p, input logic [3:0] c);
        return {p, c};
    endfunction

    task automatic add_row(input layer_ctrl_t ctrl, input layer_pxl_t o, input layer_pxl_t s1,
                           input layer_pxl_t s2, input layer_pxl_t s3, input pal_addr_t idx);
        mix_row_t r;
        r.ctrl    = ctrl;
        r.layers  = {o, s1, s2, s3};
        r.exp_idx = idx;
        rows.push_back(r);
    endtask

    task automatic check_registers();
        int        err0;
        cpu_data_t d;
        err0 = errors;
        cpu_read(12'h800, d);
        check_eq("layer reg after reset", 32'(d), 32'h0);
        cpu_read(12'h801, d);
        check_eq("raster reg after reset", 32'(d), 32'h1FF);
        cpu_write(12'h800, 16'hA5E4);
        cpu_read(12'h800, d);
        check_eq("layer reg", 32'(d), 32'hA5E4);
        cpu_write(12'h801, 16'h0064);
        cpu_read(12'h801, d);
        check_eq("raster reg", 32'(d), 32'h0064);
        cpu_read(12'h123, d);
        check_eq("palette range read", 32'(d), 32'h0);
        end_test("register port", err0);
    endtask

    task automatic check_geometry();
        int   err0, n, clks, hs_rises;
        logic hs_q, vs_q, done;
        err0 = errors;
        n    = 0;
        do begin
            vs_q = vs;
            next_cycle();
            n++;
        end while (!(vs && !vs_q) && n < FRAME_CLKS + 8);
        if (!(vs && !vs_q)) begin
            $display("timeout: no vertical sync seen within one frame");
            errors++;
        end else begin
            hs_q     = hs;
            vs_q     = vs;
            clks     = 0;
            hs_rises = 0;
            done     = 1'b0;
            n        = 0;
            while (!done && n < 2 * FRAME_CLKS) begin
                next_cycle();
                n++;
                clks++;
                check_eq("hb", 32'(hb), 32'(hdump >= `CPS_H_ACTIVE));
                check_eq("vb", 32'(vb), 32'(vdump >= `CPS_V_ACTIVE));
                if (hs && !hs_q) begin
                    if (hs_rises > 0) begin
                        check_eq("clocks per line", clks, `CPS_H_TOTAL);
                    end
                    hs_rises++;
                    clks = 0;
                end
                done = vs && !vs_q;
                hs_q = hs;
                vs_q = vs;
            end
            if (!done) begin
                $display("timeout: vertical sync did not come back within two frames");
                errors++;
            end
            check_eq("lines per frame", hs_rises, `CPS_V_TOTAL);
        end
        end_test("raster geometry", err0);
    endtask

    task automatic load_palette();
        pal_word_t w;
        for (int i = 0; i < 2**`CPS_PAL_AW; i++) begin
            random_word(w);
            mirror[i] = w;
            cpu_write({1'b0, pal_addr_t'(i)}, w);
        end
        next_cycle();
    endtask

    task automatic run_mix_rows();
        int        err0, n;
        pal_word_t w;
        foreach (rows[i]) begin
            err0 = errors;
            cpu_write(12'h800, rows[i].ctrl);
            layers = rows[i].layers;
            repeat (`CPS_PIPE_DLY + 1) next_cycle();
            n = 0;
            while (!(lhbl_dly && lvbl_dly) && n < FRAME_CLKS) begin
                next_cycle();
                n++;
            end
            if (!(lhbl_dly && lvbl_dly)) begin
                $display("timeout: no active video pixel within one frame");
                errors++;
            end else begin
                w = mirror[rows[i].exp_idx];
                check_eq("red", 32'(red), 32'(exp_channel(w[11:8], w[15:12])));
                check_eq("green", 32'(green), 32'(exp_channel(w[7:4], w[15:12])));
                check_eq("blue", 32'(blue), 32'(exp_channel(w[3:0], w[15:12])));
            end
            end_test($sformatf("mix row %0d, index %h", i, rows[i].exp_idx), err0);
        end
    endtask

    task automatic check_raster_blank();
        int         err0, pulses;
        logic [2:0] hb_h, vb_h;
        err0   = errors;
        pulses = 0;
        hb_h   = '0;
        vb_h   = '0;
        cpu_write(12'h801, 16'd150);
        for (int n = 0; n < FRAME_CLKS; n++) begin
            next_cycle();
            if (raster) begin
                pulses++;
                check_eq("raster vdump", 32'(vdump), 32'd150);
                check_eq("raster hdump", 32'(hdump), 32'd0);
            end
            // Blanking outputs trail hb and vb by three pixels
            if (n >= 3) begin
                check_eq("lhbl_dly", 32'(lhbl_dly), 32'(!hb_h[2]));
                check_eq("lvbl_dly", 32'(lvbl_dly), 32'(!vb_h[2]));
            end
            if (!lhbl_dly || !lvbl_dly) begin
                check_eq("blanked rgb", {8'h0, red, green, blue}, 32'h0);
            end
            hb_h = {hb_h[1:0], hb};
            vb_h = {vb_h[1:0], vb};
        end
        check_eq("raster pulses per frame", pulses, 1);
        end_test("raster pulse and blanking", err0);
    endtask

    initial begin
        rst        = 1'b1;
        pxl_cen    = 1'b1;
        cs         = 1'b0;
        we         = 1'b0;
        addr       = '0;
        wdata      = '0;
        layers     = '0;
        lfsr_state = 16'd26578;
        errors     = 0;
        tests      = 0;
        tests_ok   = 0;

        // Order fields in bits 7:0 and enables in bits 11:8
        add_row(16'h02E4, pxl(5'd3, 4'd2), pxl(5'd10, 4'd7), pxl(5'd1, 4'd1), pxl(5'd2, 4'd2),
                {2'd1, 5'd10, 4'd7});
        add_row(16'h0FE4, pxl(5'd4, 4'd9), pxl(5'd10, 4'd7), pxl(5'd1, 4'd1), pxl(5'd2, 4'd2),
                {2'd0, 5'd4, 4'd9});
        add_row(16'h0FE4, pxl(5'd4, 4'd15), pxl(5'd17, 4'd3), pxl(5'd1, 4'd1), pxl(5'd2, 4'd2),
                {2'd1, 5'd17, 4'd3});
        add_row(16'h0F1B, pxl(5'd4, 4'd9), pxl(5'd17, 4'd3), pxl(5'd1, 4'd1), pxl(5'd31, 4'd14),
                {2'd3, 5'd31, 4'd14});
        add_row(16'h0F1B, pxl(5'd4, 4'd9), pxl(5'd8, 4'd0), pxl(5'd1, 4'd15), pxl(5'd31, 4'd15),
                {2'd1, 5'd8, 4'd0});
        add_row(16'h0FE4, pxl(5'd4, 4'd15), pxl(5'd8, 4'd15), pxl(5'd1, 4'd15), pxl(5'd31, 4'd15),
                11'h7FF);
        add_row(16'h0EE4, pxl(5'd4, 4'd9), pxl(5'd12, 4'd5), pxl(5'd1, 4'd1), pxl(5'd2, 4'd2),
                {2'd1, 5'd12, 4'd5});
        add_row(16'h0B72, pxl(5'd20, 4'd1), pxl(5'd12, 4'd5), pxl(5'd1, 4'd1), pxl(5'd2, 4'd2),
                {2'd0, 5'd20, 4'd1});
        add_row(16'h00E4, pxl(5'd4, 4'd9), pxl(5'd12, 4'd5), pxl(5'd1, 4'd1), pxl(5'd2, 4'd2),
                11'h7FF);
        add_row(16'h0F8D, pxl(5'd4, 4'd9), pxl(5'd9, 4'd15), pxl(5'd1, 4'd1), pxl(5'd6, 4'd11),
                {2'd3, 5'd6, 4'd11});

        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        next_cycle();

        check_registers();
        check_geometry();
        load_palette();
        run_mix_rows();
        check_raster_blank();

        $display("tests run %0d, tests ok %0d, errors %0d", tests, tests_ok, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
cps_pkg.sv
cps_timing.sv
cps_mmr.sv
cps_colmix.sv
cps_palette.sv
cps_video.sv
cps_video_checker.sv
tb_cps_video.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in its output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_cps_video -f files.f -o tb_cps_video &&
{
    out="$(./obj_dir/tb_cps_video)"
    printf '%s\n' "$out"
    printf '%s\n' "$out" | grep -qx 'test passed'
} ||
{ echo "simulation did not report success"; exit 1; }
